// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rv_pipeline testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rv_pipeline -f sim.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ] || ! grep -q "Testbench passed" sim.log; then
  echo "simulation did not complete"
  exit 1
fi
exit 0

// ==== sim.f ====
source/rv_isa_pkg.sv
source/pipe_pkg.sv
source/reg_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/hazard_unit.sv
source/rv_pipeline.sv
verif/tb_rv_pipeline.sv

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [rv_isa_pkg::XLEN-1:0] fd_pc,
  input  logic [rv_isa_pkg::ILEN-1:0] fd_insn,
  input  pipe_pkg::cycle_status_e     fd_status,
  input  pipe_pkg::redirect_t         redirect,
  input  logic                        stall,
  input  pipe_pkg::wb_t               wb,
  input  logic                        wb_to_decode_rs1,
  input  logic                        wb_to_decode_rs2,
  output pipe_pkg::reg_use_t          use_d,
  output pipe_pkg::dx_t               dx
);

  rv_isa_pkg::insn_fields_t    f;
  rv_isa_pkg::alu_op_e         alu_op;
  logic [rv_isa_pkg::XLEN-1:0] imm;
  logic [rv_isa_pkg::XLEN-1:0] rf_rs1_data;
  logic [rv_isa_pkg::XLEN-1:0] rf_rs2_data;
  logic [rv_isa_pkg::XLEN-1:0] rs1_data;
  logic [rv_isa_pkg::XLEN-1:0] rs2_data;

  // alt selects sub or sra
  function automatic rv_isa_pkg::alu_op_e alu_from_funct(logic [2:0] funct3, logic alt);
    case (funct3)
      3'b000:  return alt ? rv_isa_pkg::SUB : rv_isa_pkg::ADD;
      3'b001:  return rv_isa_pkg::SLL;
      3'b010:  return rv_isa_pkg::SLT;
      3'b011:  return rv_isa_pkg::SLTU;
      3'b100:  return rv_isa_pkg::XOR;
      3'b101:  return alt ? rv_isa_pkg::SRA : rv_isa_pkg::SRL;
      3'b110:  return rv_isa_pkg::OR;
      default: return rv_isa_pkg::AND;
    endcase
  endfunction

  assign f = fd_insn;

  reg_file rf (
    .clk      (clk),
    .rst      (rst),
    .rs1      (f.rs1),
    .rs2      (f.rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data),
    .wr       (wb)
  );

  always_comb begin
    use_d     = '0;
    use_d.rs1 = f.rs1;
    use_d.rs2 = f.rs2;
    use_d.rd  = f.rd;
    alu_op    = rv_isa_pkg::ADD;
    imm       = {{20{fd_insn[31]}}, fd_insn[31:20]};
    case (f.opcode)
      rv_isa_pkg::LUI: begin
        imm             = {fd_insn[31:12], 12'b0};
        alu_op          = rv_isa_pkg::PASS_B;
        use_d.writes_rd = 1'b1;
      end
      rv_isa_pkg::REG_IMM: begin
        // imm[10] only means arithmetic for the right shift
        alu_op          = alu_from_funct(f.funct3, f.funct7[5] && f.funct3 == 3'b101);
        use_d.uses_rs1  = 1'b1;
        use_d.writes_rd = 1'b1;
      end
      rv_isa_pkg::REG_REG: begin
        alu_op          = alu_from_funct(f.funct3, f.funct7[5]);
        use_d.uses_rs1  = 1'b1;
        use_d.uses_rs2  = 1'b1;
        use_d.writes_rd = 1'b1;
      end
      rv_isa_pkg::LOAD: begin
        use_d.uses_rs1  = 1'b1;
        use_d.writes_rd = 1'b1;
      end
      rv_isa_pkg::STORE: begin
        imm            = {{20{fd_insn[31]}}, fd_insn[31:25], fd_insn[11:7]};
        use_d.uses_rs1 = 1'b1;
        use_d.uses_rs2 = 1'b1;
      end
      rv_isa_pkg::BRANCH: begin
        imm = {{19{fd_insn[31]}}, fd_insn[31], fd_insn[7], fd_insn[30:25], fd_insn[11:8], 1'b0};
        use_d.uses_rs1 = 1'b1;
        use_d.uses_rs2 = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // same-cycle writeback is not yet in the register file
  assign rs1_data = wb_to_decode_rs1 ? wb.data : rf_rs1_data;
  assign rs2_data = wb_to_decode_rs2 ? wb.data : rf_rs2_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      dx        <= '0;
      dx.status <= pipe_pkg::CYCLE_RESET;
    end else if (redirect.taken) begin
      dx        <= '0;
      dx.status <= pipe_pkg::CYCLE_TAKEN_BRANCH;
    end else if (stall) begin
      // held instruction still picks up the value retiring now
      if (wb.we && wb.rd != '0 && wb.rd == dx.reg_use.rs1) begin
        dx.rs1_data <= wb.data;
      end
      if (wb.we && wb.rd != '0 && wb.rd == dx.reg_use.rs2) begin
        dx.rs2_data <= wb.data;
      end
    end else begin
      dx <= '{pc: fd_pc, insn: fd_insn, reg_use: use_d, alu_op: alu_op, imm: imm,
              rs1_data: rs1_data, rs2_data: rs2_data, status: fd_status};
    end
  end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  logic                        clk,
  input  logic                        rst,
  input  pipe_pkg::dx_t               dx,
  input  pipe_pkg::fwd_sel_e          fwd_rs1,
  input  pipe_pkg::fwd_sel_e          fwd_rs2,
  input  logic [rv_isa_pkg::XLEN-1:0] mem_result,
  input  pipe_pkg::wb_t               wb,
  input  logic                        stall,
  output pipe_pkg::redirect_t         redirect,
  output pipe_pkg::xm_t               xm
);

  rv_isa_pkg::insn_fields_t    f;
  logic [rv_isa_pkg::XLEN-1:0] op_a;
  logic [rv_isa_pkg::XLEN-1:0] rs2_val;
  logic [rv_isa_pkg::XLEN-1:0] op_b;
  logic [rv_isa_pkg::XLEN-1:0] result;
  logic                        cond_true;

  function automatic logic [rv_isa_pkg::XLEN-1:0] pick(
    pipe_pkg::fwd_sel_e sel,
    logic [rv_isa_pkg::XLEN-1:0] reg_val,
    logic [rv_isa_pkg::XLEN-1:0] m_val,
    logic [rv_isa_pkg::XLEN-1:0] w_val
  );
    case (sel)
      pipe_pkg::FWD_MEM: return m_val;
      pipe_pkg::FWD_WB:  return w_val;
      default:           return reg_val;
    endcase
  endfunction

  assign f       = dx.insn;
  assign op_a    = pick(fwd_rs1, dx.rs1_data, mem_result, wb.data);
  assign rs2_val = pick(fwd_rs2, dx.rs2_data, mem_result, wb.data);
  // loads and stores add the immediate to rs1 for the address
  assign op_b    = (f.opcode == rv_isa_pkg::REG_REG) ? rs2_val : dx.imm;

  always_comb begin
    case (dx.alu_op)
      rv_isa_pkg::ADD:  result = op_a + op_b;
      rv_isa_pkg::SUB:  result = op_a - op_b;
      rv_isa_pkg::SLL:  result = op_a << op_b[4:0];
      rv_isa_pkg::SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_isa_pkg::SLTU: result = {31'b0, op_a < op_b};
      rv_isa_pkg::XOR:  result = op_a ^ op_b;
      rv_isa_pkg::SRL:  result = op_a >> op_b[4:0];
      rv_isa_pkg::SRA:  result = $signed(op_a) >>> op_b[4:0];
      rv_isa_pkg::OR:   result = op_a | op_b;
      rv_isa_pkg::AND:  result = op_a & op_b;
      default:          result = op_b;
    endcase
  end

  always_comb begin
    case (rv_isa_pkg::branch_cond_e'(f.funct3))
      rv_isa_pkg::BEQ:  cond_true = op_a == rs2_val;
      rv_isa_pkg::BNE:  cond_true = op_a != rs2_val;
      rv_isa_pkg::BLT:  cond_true = $signed(op_a) < $signed(rs2_val);
      rv_isa_pkg::BGE:  cond_true = $signed(op_a) >= $signed(rs2_val);
      rv_isa_pkg::BLTU: cond_true = op_a < rs2_val;
      default:          cond_true = op_a >= rs2_val;
    endcase
  end

  // operands are not final while a load-to-use stall is pending
  assign redirect.taken  = f.opcode == rv_isa_pkg::BRANCH && cond_true && !stall;
  assign redirect.target = dx.pc + dx.imm;

  always_ff @(posedge clk) begin
    if (rst) begin
      xm        <= '0;
      xm.status <= pipe_pkg::CYCLE_RESET;
    end else if (stall) begin
      xm        <= '0;
      xm.status <= pipe_pkg::CYCLE_LOAD2USE;
    end else begin
      xm <= '{pc: dx.pc, insn: dx.insn, reg_use: dx.reg_use, result: result,
              store_data: rs2_val, status: dx.status};
    end
  end

  // no compressed fetch so a taken target must sit on a word boundary
  assert property (@(posedge clk) disable iff (rst)
    redirect.taken |-> redirect.target[1:0] == 2'b00);

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
  input  logic                        clk,
  input  logic                        rst,
  input  pipe_pkg::redirect_t         redirect,
  input  logic                        stall,
  output logic [rv_isa_pkg::XLEN-1:0] imem_pc,
  input  logic [rv_isa_pkg::ILEN-1:0] imem_insn,
  output logic [rv_isa_pkg::XLEN-1:0] fd_pc,
  output logic [rv_isa_pkg::ILEN-1:0] fd_insn,
  output pipe_pkg::cycle_status_e     fd_status
);

  logic [rv_isa_pkg::XLEN-1:0] pc;
  logic [rv_isa_pkg::XLEN-1:0] pc_next;

  // redirect wins over stall
  always_comb begin
    if (redirect.taken) begin
      pc_next = redirect.target;
    end else if (stall) begin
      pc_next = pc;
    end else begin
      pc_next = pc + 4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  assign imem_pc = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      fd_pc     <= '0;
      fd_insn   <= '0;
      fd_status <= pipe_pkg::CYCLE_RESET;
    end else if (redirect.taken) begin
      // wrong-path fetch becomes a bubble
      fd_pc     <= '0;
      fd_insn   <= '0;
      fd_status <= pipe_pkg::CYCLE_TAKEN_BRANCH;
    end else if (!stall) begin
      fd_pc     <= pc;
      fd_insn   <= imem_insn;
      fd_status <= pipe_pkg::CYCLE_NO_STALL;
    end
  end

endmodule

// ==== source/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
  input  pipe_pkg::reg_use_t use_d,
  input  pipe_pkg::reg_use_t use_x,
  input  pipe_pkg::reg_use_t use_m,
  input  pipe_pkg::reg_use_t use_w,
  input  logic               m_is_load,
  output pipe_pkg::fwd_sel_e fwd_rs1,
  output pipe_pkg::fwd_sel_e fwd_rs2,
  output logic               wb_to_decode_rs1,
  output logic               wb_to_decode_rs2,
  output logic               wb_to_store,
  output logic               load_stall
);

  logic m_rs1;
  logic m_rs2;
  logic w_rs1;
  logic w_rs2;

  function automatic logic hit(
    pipe_pkg::reg_use_t prod,
    logic [rv_isa_pkg::REG_ADDR_W-1:0] src,
    logic used
  );
    return used && prod.writes_rd && prod.rd != '0 && prod.rd == src;
  endfunction

  assign m_rs1 = hit(use_m, use_x.rs1, use_x.uses_rs1);
  assign m_rs2 = hit(use_m, use_x.rs2, use_x.uses_rs2);
  assign w_rs1 = hit(use_w, use_x.rs1, use_x.uses_rs1);
  assign w_rs2 = hit(use_w, use_x.rs2, use_x.uses_rs2);

  // a load in memory stalls its user instead of forwarding
  assign load_stall = m_is_load && (m_rs1 || m_rs2);

  // memory is the younger producer
  assign fwd_rs1 = (m_rs1 && !m_is_load) ? pipe_pkg::FWD_MEM :
                   w_rs1 ? pipe_pkg::FWD_WB : pipe_pkg::FWD_NONE;
  assign fwd_rs2 = (m_rs2 && !m_is_load) ? pipe_pkg::FWD_MEM :
                   w_rs2 ? pipe_pkg::FWD_WB : pipe_pkg::FWD_NONE;

  assign wb_to_decode_rs1 = hit(use_w, use_d.rs1, use_d.uses_rs1);
  assign wb_to_decode_rs2 = hit(use_w, use_d.rs2, use_d.uses_rs2);
  assign wb_to_store      = hit(use_w, use_m.rs2, use_m.uses_rs2);

endmodule

// ==== source/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
  input  logic                        clk,
  input  logic                        rst,
  input  pipe_pkg::xm_t               xm,
  input  logic                        wb_to_store,
  input  logic [rv_isa_pkg::XLEN-1:0] dmem_rdata,
  output pipe_pkg::dmem_req_t         dmem_req,
  output logic [rv_isa_pkg::XLEN-1:0] mem_result,
  output pipe_pkg::wb_t               wb,
  output logic                        halt,
  output pipe_pkg::retire_t           trace
);

  rv_isa_pkg::insn_fields_t    f;
  rv_isa_pkg::mem_size_e       size;
  logic [1:0]                  offset;
  logic                        is_store;
  logic                        is_load;
  logic [rv_isa_pkg::XLEN-1:0] sdata;
  logic [rv_isa_pkg::XLEN-1:0] lane_data;
  logic [rv_isa_pkg::XLEN-1:0] load_val;
  pipe_pkg::retire_t           w_trace;
  pipe_pkg::reg_use_t          w_use;
  logic [rv_isa_pkg::XLEN-1:0] w_data;

  assign f        = xm.insn;
  assign size     = rv_isa_pkg::mem_size_e'(f.funct3);
  assign offset   = xm.result[1:0];
  assign is_store = f.opcode == rv_isa_pkg::STORE;
  assign is_load  = f.opcode == rv_isa_pkg::LOAD;
  assign sdata    = wb_to_store ? wb.data : xm.store_data;

  // narrow data goes to every lane and the enables select the live one
  always_comb begin
    dmem_req.addr = {xm.result[rv_isa_pkg::XLEN-1:2], 2'b00};
    case (size)
      rv_isa_pkg::MEM_B: begin
        dmem_req.wdata = {rv_isa_pkg::BYTE_LANES{sdata[7:0]}};
        dmem_req.we    = 4'b0001 << offset;
      end
      rv_isa_pkg::MEM_H: begin
        dmem_req.wdata = {2{sdata[15:0]}};
        dmem_req.we    = 4'b0011 << offset;
      end
      default: begin
        dmem_req.wdata = sdata;
        dmem_req.we    = 4'b1111;
      end
    endcase
    if (!is_store) begin
      dmem_req.we = '0;
    end
  end

  assign lane_data = dmem_rdata >> {offset, 3'b000};

  always_comb begin
    case (size)
      rv_isa_pkg::MEM_B:  load_val = {{24{lane_data[7]}}, lane_data[7:0]};
      rv_isa_pkg::MEM_H:  load_val = {{16{lane_data[15]}}, lane_data[15:0]};
      rv_isa_pkg::MEM_BU: load_val = {24'b0, lane_data[7:0]};
      rv_isa_pkg::MEM_HU: load_val = {16'b0, lane_data[15:0]};
      default:            load_val = lane_data;
    endcase
  end

  assign mem_result = is_load ? load_val : xm.result;

  always_ff @(posedge clk) begin
    if (rst) begin
      w_trace        <= '0;
      w_trace.status <= pipe_pkg::CYCLE_RESET;
      w_use          <= '0;
    end else begin
      w_trace <= '{pc: xm.pc, insn: xm.insn, status: xm.status};
      w_use   <= xm.reg_use;
    end
  end

  always_ff @(posedge clk) begin
    w_data <= mem_result;
  end

  assign wb.we   = w_use.writes_rd && w_trace.status == pipe_pkg::CYCLE_NO_STALL;
  assign wb.rd   = w_use.rd;
  assign wb.data = w_data;

  // ecall has every bit above the opcode clear
  assign halt = w_trace.insn[6:0] == rv_isa_pkg::SYSTEM && w_trace.insn[31:7] == '0 &&
                w_trace.status == pipe_pkg::CYCLE_NO_STALL;

  assign trace = w_trace;

  // only a real store that came down the pipe may drive lane enables
  assert property (@(posedge clk) disable iff (rst)
    dmem_req.we != '0 |-> is_store && xm.status == pipe_pkg::CYCLE_NO_STALL);

endmodule

// ==== source/pipe_pkg.sv ====
package pipe_pkg;

  // what occupies writeback in a given cycle
  typedef enum logic [3:0] {
    CYCLE_INVALID      = 4'd0,
    CYCLE_RESET        = 4'd1,
    CYCLE_NO_STALL     = 4'd2,
    CYCLE_TAKEN_BRANCH = 4'd4,
    CYCLE_LOAD2USE     = 4'd8
  } cycle_status_e;

  typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

  typedef struct packed {
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
    logic                              uses_rs1;
    logic                              uses_rs2;
    logic                              writes_rd;
  } reg_use_t;

  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0] pc;
    logic [rv_isa_pkg::ILEN-1:0] insn;
    reg_use_t                    reg_use;
    rv_isa_pkg::alu_op_e         alu_op;
    logic [rv_isa_pkg::XLEN-1:0] imm;
    logic [rv_isa_pkg::XLEN-1:0] rs1_data;
    logic [rv_isa_pkg::XLEN-1:0] rs2_data;
    cycle_status_e               status;
  } dx_t;

  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0] pc;
    logic [rv_isa_pkg::ILEN-1:0] insn;
    reg_use_t                    reg_use;
    logic [rv_isa_pkg::XLEN-1:0] result;
    logic [rv_isa_pkg::XLEN-1:0] store_data;
    cycle_status_e               status;
  } xm_t;

  // register write request
  typedef struct packed {
    logic                              we;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_isa_pkg::XLEN-1:0]       data;
  } wb_t;

  typedef struct packed {
    logic                        taken;
    logic [rv_isa_pkg::XLEN-1:0] target;
  } redirect_t;

  // addr is word aligned, we has one bit per byte lane
  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0]       addr;
    logic [rv_isa_pkg::XLEN-1:0]       wdata;
    logic [rv_isa_pkg::BYTE_LANES-1:0] we;
  } dmem_req_t;

  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0] pc;
    logic [rv_isa_pkg::ILEN-1:0] insn;
    cycle_status_e               status;
  } retire_t;

endpackage

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2,
  output logic [rv_isa_pkg::XLEN-1:0]       rs1_data,
  output logic [rv_isa_pkg::XLEN-1:0]       rs2_data,
  input  pipe_pkg::wb_t                     wr
);

  // x0 has no storage
  logic [rv_isa_pkg::XLEN-1:0] regs [1:rv_isa_pkg::NUM_REGS-1];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < rv_isa_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.we && wr.rd != '0) begin
      regs[wr.rd] <= wr.data;
    end
  end

  // write port stays idle once reset has been applied
  assert property (@(posedge clk) rst |=> !wr.we);

endmodule

// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

  localparam int XLEN       = 32;
  localparam int ILEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam int BYTE_LANES = 4;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    BRANCH  = 7'b1100011,
    REG_IMM = 7'b0010011,
    REG_REG = 7'b0110011,
    SYSTEM  = 7'b1110011,
    LUI     = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR,
    SRL, SRA, OR, AND, PASS_B
  } alu_op_e;

  // encodings follow funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_cond_e;

  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101
  } mem_size_e;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    opcode_e               opcode;
  } insn_fields_t;

endpackage

// ==== source/rv_pipeline.sv ====
`timescale 1ns/1ps

module rv_pipeline (
  input  logic                        clk,
  input  logic                        rst,
  output logic [rv_isa_pkg::XLEN-1:0] imem_pc,
  input  logic [rv_isa_pkg::ILEN-1:0] imem_insn,
  output pipe_pkg::dmem_req_t         dmem_req,
  input  logic [rv_isa_pkg::XLEN-1:0] dmem_rdata,
  output logic                        halt,
  output pipe_pkg::retire_t           trace
);

  pipe_pkg::redirect_t         redirect;
  logic                        load_stall;
  logic [rv_isa_pkg::XLEN-1:0] fd_pc;
  logic [rv_isa_pkg::ILEN-1:0] fd_insn;
  pipe_pkg::cycle_status_e     fd_status;
  pipe_pkg::reg_use_t          use_d;
  pipe_pkg::reg_use_t          use_w;
  pipe_pkg::dx_t               dx;
  pipe_pkg::xm_t               xm;
  pipe_pkg::wb_t               wb;
  logic [rv_isa_pkg::XLEN-1:0] mem_result;
  pipe_pkg::fwd_sel_e          fwd_rs1;
  pipe_pkg::fwd_sel_e          fwd_rs2;
  logic                        wb_to_decode_rs1;
  logic                        wb_to_decode_rs2;
  logic                        wb_to_store;
  logic                        m_is_load;

  // writeback producer seen by the hazard unit
  assign use_w = '{rs1: '0, rs2: '0, rd: wb.rd, uses_rs1: 1'b0, uses_rs2: 1'b0,
                   writes_rd: wb.we};
  assign m_is_load = xm.insn[6:0] == rv_isa_pkg::LOAD;

  fetch_stage u_fetch (
    .clk (clk), .rst (rst), .redirect (redirect), .stall (load_stall),
    .imem_pc (imem_pc), .imem_insn (imem_insn),
    .fd_pc (fd_pc), .fd_insn (fd_insn), .fd_status (fd_status)
  );

  decode_stage u_decode (
    .clk (clk), .rst (rst), .fd_pc (fd_pc), .fd_insn (fd_insn), .fd_status (fd_status),
    .redirect (redirect), .stall (load_stall), .wb (wb),
    .wb_to_decode_rs1 (wb_to_decode_rs1), .wb_to_decode_rs2 (wb_to_decode_rs2),
    .use_d (use_d), .dx (dx)
  );

  execute_stage u_execute (
    .clk (clk), .rst (rst), .dx (dx), .fwd_rs1 (fwd_rs1), .fwd_rs2 (fwd_rs2),
    .mem_result (mem_result), .wb (wb), .stall (load_stall),
    .redirect (redirect), .xm (xm)
  );

  memory_stage u_memory (
    .clk (clk), .rst (rst), .xm (xm), .wb_to_store (wb_to_store),
    .dmem_rdata (dmem_rdata), .dmem_req (dmem_req), .mem_result (mem_result),
    .wb (wb), .halt (halt), .trace (trace)
  );

  hazard_unit u_hazard (
    .use_d (use_d), .use_x (dx.reg_use), .use_m (xm.reg_use), .use_w (use_w),
    .m_is_load (m_is_load), .fwd_rs1 (fwd_rs1), .fwd_rs2 (fwd_rs2),
    .wb_to_decode_rs1 (wb_to_decode_rs1), .wb_to_decode_rs2 (wb_to_decode_rs2),
    .wb_to_store (wb_to_store), .load_stall (load_stall)
  );

endmodule

// ==== verif/tb_rv_pipeline.sv ====
`timescale 1ns/1ps

module tb_rv_pipeline;

  localparam int RESET_CYCLES = 8;
  localparam int PROG_LEN     = 150;
  localparam int NUM_ECALL    = 8;
  localparam int MAX_CYCLES   = RESET_CYCLES + PROG_LEN * 3 + 40;
  localparam logic [31:0] DATA_BASE = 32'h0000_0400;
  localparam logic [31:0] ECALL     = 32'h0000_0073;

  logic                       clk;
  logic                       rst;
  logic [31:0]                imem_pc;
  logic [31:0]                imem_insn;
  pipe_pkg::dmem_req_t        dmem_req;
  logic [31:0]                dmem_rdata;
  logic                       halt;
  pipe_pkg::retire_t          trace;

  // program and data memories
  logic [31:0] imem      [0:255];
  logic [31:0] dmem      [0:63];
  logic [31:0] dmem_init [0:63];

  // expected trace and store sequences from the model
  pipe_pkg::cycle_status_e exp_status[$];
  logic [31:0]             exp_pc[$];
  logic [31:0]             exp_insn[$];
  logic [31:0]             st_addr[$];
  logic [3:0]              st_mask[$];
  logic [31:0]             st_data[$];

  integer seed;
  int     cycles;
  int     ti;
  int     si;
  logic   started;
  logic   done;

  rv_pipeline UUT (
    .clk        (clk),
    .rst        (rst),
    .imem_pc    (imem_pc),
    .imem_insn  (imem_insn),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .halt       (halt),
    .trace      (trace)
  );

  always #20 clk = ~clk;

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic stop_with_error(string what);
    $display("%0t: %s", $time, what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  function automatic int pick_below(int n);
    logic [31:0] r;
    r = $random(seed);
    return r % n;
  endfunction

  function automatic logic [31:0] byte_bits(logic [3:0] m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  // x0..x7 only, so operands collide often
  task automatic build_program();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [2:0]  load_sizes [0:4];
    logic [2:0]  conds [0:5];
    int          kind;
    int          off;
    load_sizes = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    conds      = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    for (int i = 0; i < 256; i++) begin
      // addi x0, x0, word index
      imem[i] = enc_i(i[11:0], 5'd0, 3'd0, 5'd0, 7'b0010011);
    end
    for (int i = 0; i < 64; i++) begin
      dmem_init[i] = $random(seed);
      dmem[i]      = dmem_init[i];
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      kind = pick_below(8);
      rd   = 5'(pick_below(8));
      rs1  = 5'(pick_below(8));
      rs2  = 5'(pick_below(8));
      f3   = 3'(pick_below(8));
      imm  = 12'($random(seed));
      if (kind == 5 && i >= PROG_LEN - 4) begin
        kind = 1;
      end
      case (kind)
        0: imem[i] = {20'($random(seed)), rd, 7'b0110111};
        1, 6: begin
          if (f3 == 3'd1) begin
            imm = {7'b0, imm[4:0]};
          end else if (f3 == 3'd5) begin
            imm = {1'b0, imm[10], 5'b0, imm[4:0]};
          end
          imem[i] = enc_i(imm, rs1, f3, rd, 7'b0010011);
        end
        2, 7: begin
          imem[i] = {((f3 == 3'd0 || f3 == 3'd5) && imm[0]) ? 7'h20 : 7'h00,
                     rs2, rs1, f3, rd, 7'b0110011};
        end
        3: begin
          f3  = load_sizes[pick_below(5)];
          off = pick_below(256);
          if (f3[1:0] == 2'd1) off = off & ~1;
          if (f3[1:0] == 2'd2) off = off & ~3;
          imem[i] = enc_i(12'(DATA_BASE + off), 5'd0, f3, rd, 7'b0000011);
        end
        4: begin
          f3  = 3'(pick_below(3));
          off = pick_below(256);
          if (f3 == 3'd1) off = off & ~1;
          if (f3 == 3'd2) off = off & ~3;
          imem[i] = enc_s(12'(DATA_BASE + off), rs2, 5'd0, f3);
        end
        default: begin
          off     = 8 + 4 * pick_below(3);
          imem[i] = enc_b(13'(off), rs2, rs1, conds[pick_below(6)]);
        end
      endcase
    end
    for (int i = PROG_LEN; i < PROG_LEN + NUM_ECALL; i++) begin
      imem[i] = ECALL;
    end
  endtask

  function automatic logic [31:0] alu_model(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'b0, $signed(a) < $signed(b)};
      3'd3: r = {31'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_model(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic push_trace(pipe_pkg::cycle_status_e st, logic [31:0] pc, logic [31:0] insn);
    exp_status.push_back(st);
    exp_pc.push_back(pc);
    exp_insn.push_back(insn);
  endtask

  // instruction-level run up to the first ecall
  task automatic run_model();
    logic [31:0] regs [0:31];
    logic [31:0] dm   [0:63];
    logic [31:0] pc;
    logic [31:0] insn;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] w;
    logic [31:0] data;
    logic [6:0]  op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  pend;
    logic [2:0]  f3;
    logic [3:0]  mask;
    logic        u1;
    logic        u2;
    logic        wr;
    logic        taken;
    logic        l2u;
    logic        fin;
    int          idx;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < 64; i++) dm[i] = dmem_init[i];
    pc   = '0;
    pend = '0;
    fin  = 1'b0;
    while (!fin) begin
      insn  = imem[pc[9:2]];
      op    = insn[6:0];
      rd    = insn[11:7];
      f3    = insn[14:12];
      rs1   = insn[19:15];
      rs2   = insn[24:20];
      a     = regs[rs1];
      b     = regs[rs2];
      u1    = op inside {7'b0010011, 7'b0110011, 7'b0000011, 7'b0100011, 7'b1100011};
      u2    = op inside {7'b0110011, 7'b0100011, 7'b1100011};
      l2u   = pend != '0 && ((u1 && rs1 == pend) || (u2 && rs2 == pend));
      pend  = '0;
      wr    = 1'b0;
      taken = 1'b0;
      res   = '0;
      case (op)
        7'b0110111: begin
          res = {insn[31:12], 12'b0};
          wr  = 1'b1;
        end
        7'b0010011: begin
          res = alu_model(f3, f3 == 3'd5 && insn[30], a, {{20{insn[31]}}, insn[31:20]});
          wr  = 1'b1;
        end
        7'b0110011: begin
          res = alu_model(f3, insn[30], a, b);
          wr  = 1'b1;
        end
        7'b0000011: begin
          addr = a + {{20{insn[31]}}, insn[31:20]};
          idx  = (addr - DATA_BASE) >> 2;
          w    = dm[idx] >> {addr[1:0], 3'b000};
          case (f3)
            3'd0: res = {{24{w[7]}}, w[7:0]};
            3'd1: res = {{16{w[15]}}, w[15:0]};
            3'd4: res = {24'b0, w[7:0]};
            3'd5: res = {16'b0, w[15:0]};
            default: res = w;
          endcase
          wr   = 1'b1;
          pend = rd;
        end
        7'b0100011: begin
          addr = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
          idx  = (addr - DATA_BASE) >> 2;
          data = b << {addr[1:0], 3'b000};
          if (f3 == 3'd0) begin
            mask = 4'b0001 << addr[1:0];
          end else if (f3 == 3'd1) begin
            mask = 4'b0011 << addr[1:0];
          end else begin
            mask = 4'b1111;
          end
          dm[idx] = (dm[idx] & ~byte_bits(mask)) | (data & byte_bits(mask));
          st_addr.push_back({addr[31:2], 2'b00});
          st_mask.push_back(mask);
          st_data.push_back(data);
        end
        7'b1100011: taken = branch_model(f3, a, b);
        default: fin = 1'b1;
      endcase
      if (wr && rd != '0) regs[rd] = res;
      if (l2u) push_trace(pipe_pkg::CYCLE_LOAD2USE, '0, '0);
      push_trace(pipe_pkg::CYCLE_NO_STALL, pc, insn);
      if (taken) begin
        push_trace(pipe_pkg::CYCLE_TAKEN_BRANCH, '0, '0);
        push_trace(pipe_pkg::CYCLE_TAKEN_BRANCH, '0, '0);
        pc = pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      end else begin
        pc = pc + 4;
      end
    end
  endtask

  task automatic check_outputs();
    if (rst) begin
      check_value("trace.status", 32'(trace.status), 32'(pipe_pkg::CYCLE_RESET));
      // fetch restarts from address zero
      check_value("imem_pc", imem_pc, 32'd0);
    end
    if (!started && trace.status == pipe_pkg::CYCLE_RESET) begin
      check_value("halt", 32'(halt), 32'd0);
      check_value("dmem_req.we", 32'(dmem_req.we), 32'd0);
    end else begin
      started = 1'b1;
      if (ti >= exp_status.size()) begin
        stop_with_error("trace kept going after the model's last expected cycle");
      end
      check_value("trace.status", 32'(trace.status), 32'(exp_status[ti]));
      if (trace.status == pipe_pkg::CYCLE_NO_STALL) begin
        check_value("trace.pc", trace.pc, exp_pc[ti]);
        check_value("trace.insn", trace.insn, exp_insn[ti]);
      end
      if (exp_insn[ti] == ECALL) begin
        check_value("halt", 32'(halt), 32'd1);
        if (si != st_addr.size()) begin
          stop_with_error("halt came before all expected stores were seen");
        end
        done = 1'b1;
      end else begin
        check_value("halt", 32'(halt), 32'd0);
      end
      ti++;
    end
    if (dmem_req.we != '0) begin
      if (si >= st_addr.size()) begin
        stop_with_error("the DUT stored more often than the program does");
      end
      check_value("dmem_req.addr", dmem_req.addr, st_addr[si]);
      check_value("dmem_req.we", 32'(dmem_req.we), 32'(st_mask[si]));
      check_value("dmem_req.wdata", dmem_req.wdata & byte_bits(st_mask[si]),
                  st_data[si] & byte_bits(st_mask[si]));
      si++;
    end
  endtask

  task automatic drive_memories();
    int idx;
    logic in_range;
    imem_insn = imem[imem_pc[9:2]];
    in_range  = dmem_req.addr >= DATA_BASE && dmem_req.addr < DATA_BASE + 256;
    idx       = (dmem_req.addr - DATA_BASE) >> 2;
    if (in_range && dmem_req.we != '0) begin
      dmem[idx] = (dmem[idx] & ~byte_bits(dmem_req.we)) |
                  (dmem_req.wdata & byte_bits(dmem_req.we));
    end
    dmem_rdata = in_range ? dmem[idx] : '0;
  endtask

  initial begin
    seed       = 44563;
    clk        = 1'b0;
    rst        = 1'b1;
    imem_insn  = '0;
    dmem_rdata = '0;
    cycles     = 0;
    ti         = 0;
    si         = 0;
    started    = 1'b0;
    done       = 1'b0;
    build_program();
    run_model();
    while (!done) begin
      @(negedge clk);
      cycles++;
      check_outputs();
      drive_memories();
      if (cycles == RESET_CYCLES) begin
        rst = 1'b0;
      end
      if (!done && cycles >= MAX_CYCLES) begin
        stop_with_error("timeout, halt was not seen in time");
      end
    end
    $display("Testbench passed");
    $finish;
  end

endmodule
